// ==== logic/lsu_pkg.sv ====
// data memory shared types
package lsu_pkg;

   localparam int mem_bytes = 4096;
   localparam int addr_w    = 12;
   localparam int data_w    = 32;

   // code 0 is reserved and never legal on the SRAM
   typedef enum logic [2:0] {
      size_byte = 3'd1,
      size_half = 3'd2,
      size_word = 3'd3
   } lsu_size_t;

   typedef struct packed {
      logic [addr_w-1:0] addr;
      lsu_size_t         size;
      logic              we;
      logic              signed_ld;   // sign-extend byte and half loads
      logic [data_w-1:0] wdata;
   } lsu_req_t;

   typedef struct packed {
      logic [data_w-1:0] rdata;
      logic              fault;
   } lsu_rsp_t;

   // limit needs one extra bit so that it can hold mem_bytes itself
   typedef struct packed {
      logic [addr_w-1:0] base;
      logic [addr_w:0]   limit;
   } win_t;

   typedef enum logic [1:0] {
      sel_base   = 2'd0,
      sel_limit  = 2'd1,
      sel_faults = 2'd2
   } cfg_sel_t;

   typedef struct packed {
      logic              write;
      cfg_sel_t          sel;
      logic [data_w-1:0] wdata;
   } cfg_cmd_t;

endpackage

// ==== logic/handshake_sram.sv ====
// byte addressable data SRAM
`timescale 1ns/10ps

module handshake_sram (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic [lsu_pkg::addr_w-1:0] addr,
   input  lsu_pkg::lsu_size_t         size,
   input  logic [lsu_pkg::data_w-1:0] wdata,
   input  logic                       wr_valid,
   input  logic                       rd_ready,
   output logic                       wr_ready,
   output logic                       rd_valid,
   output logic [lsu_pkg::data_w-1:0] rdata
);
   import lsu_pkg::*;

   logic [7:0]        mem [0:mem_bytes-1];
   logic [addr_w-1:0] addr_p1;
   logic [addr_w-1:0] addr_p2;
   logic [addr_w-1:0] addr_p3;
   logic [data_w-1:0] rdata_nxt;

   assign addr_p1 = addr + addr_w'(1);
   assign addr_p2 = addr + addr_w'(2);
   assign addr_p3 = addr + addr_w'(3);

   // bytes are gathered little-endian and the upper bytes read as zero for narrow sizes
   always_comb begin
      case (size)
         size_word: rdata_nxt = {mem[addr_p3], mem[addr_p2], mem[addr_p1], mem[addr]};
         size_half: rdata_nxt = {16'h0000, mem[addr_p1], mem[addr]};
         default:   rdata_nxt = {24'h00_0000, mem[addr]};
      endcase
   end

   always_ff @(posedge clk) begin
      if (wr_valid) begin
         case (size)
            size_word: begin
               mem[addr_p3] <= wdata[31:24];
               mem[addr_p2] <= wdata[23:16];
               mem[addr_p1] <= wdata[15:8];
               mem[addr]    <= wdata[7:0];
            end
            size_half: begin
               mem[addr_p1] <= wdata[15:8];
               mem[addr]    <= wdata[7:0];
            end
            size_byte: begin
               mem[addr] <= wdata[7:0];
            end
            default: begin
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (rd_ready)
         rdata <= rdata_nxt;   // held until the next read strobe
   end

   // both echoes come back exactly one cycle after their strobe
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ready <= 1'b0;
         rd_valid <= 1'b0;
      end else begin
         wr_ready <= wr_valid;
         rd_valid <= rd_ready;
      end
   end

   chk_size: assert property (@(posedge clk) disable iff (!rst_n)
      (wr_valid || rd_ready) |-> (size != 3'd0))
      else $error("size code 0 presented with an SRAM strobe");

endmodule

// ==== logic/lsu_ctrl.sv ====
// load store access controller
`timescale 1ns/10ps

module lsu_ctrl (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic                       req_valid,
   output logic                       req_ready,
   input  lsu_pkg::lsu_req_t          req,
   output logic                       rsp_valid,
   input  logic                       rsp_ready,
   output lsu_pkg::lsu_rsp_t          rsp,
   input  lsu_pkg::win_t              win,
   output logic                       fault_pulse,
   output logic [lsu_pkg::addr_w-1:0] addr,
   output lsu_pkg::lsu_size_t         size,
   output logic [lsu_pkg::data_w-1:0] wdata,
   output logic                       wr_valid,
   output logic                       rd_ready,
   input  logic                       wr_ready,
   input  logic                       rd_valid,
   input  logic [lsu_pkg::data_w-1:0] rdata
);
   import lsu_pkg::*;

   typedef enum logic [1:0] {
      st_idle,
      st_issue,
      st_wait,
      st_resp
   } state_t;

   state_t            state;
   lsu_req_t          req_q;
   logic              accept;
   logic              misaligned;
   logic              in_window;
   logic              bad_req;
   logic [addr_w:0]   acc_bytes;
   logic [addr_w:0]   acc_end;
   logic              sram_done;
   logic [data_w-1:0] ld_data;

   // checks run on the incoming request so a fault can answer one cycle later
   always_comb begin
      acc_bytes  = (addr_w+1)'(1);
      misaligned = 1'b0;
      case (req.size)
         size_half: begin
            acc_bytes  = (addr_w+1)'(2);
            misaligned = req.addr[0];
         end
         size_word: begin
            acc_bytes  = (addr_w+1)'(4);
            misaligned = |req.addr[1:0];
         end
         default: begin
         end
      endcase
   end

   assign acc_end   = {1'b0, req.addr} + acc_bytes;
   assign in_window = (req.addr >= win.base) && (acc_end <= win.limit);
   assign bad_req   = misaligned || !in_window;

   assign req_ready   = (state == st_idle);
   assign accept      = req_valid && req_ready;
   assign fault_pulse = accept && bad_req;
   assign rsp_valid   = (state == st_resp);

   assign addr     = req_q.addr;
   assign size     = req_q.size;
   assign wdata    = req_q.wdata;
   assign wr_valid = (state == st_issue) && req_q.we;
   assign rd_ready = (state == st_issue) && !req_q.we;

   assign sram_done = req_q.we ? wr_ready : rd_valid;

   always_comb begin
      case (req_q.size)
         size_byte: ld_data = {{24{req_q.signed_ld & rdata[7]}}, rdata[7:0]};
         size_half: ld_data = {{16{req_q.signed_ld & rdata[15]}}, rdata[15:0]};
         default:   ld_data = rdata;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= st_idle;
      end else begin
         case (state)
            st_idle:  if (accept) state <= bad_req ? st_resp : st_issue;
            st_issue: state <= st_wait;
            st_wait:  if (sram_done) state <= st_resp;
            st_resp:  if (rsp_ready) state <= st_idle;
            default:  state <= st_idle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         req_q <= req;
         rsp   <= '{rdata: '0, fault: bad_req};
      end else if (state == st_wait && sram_done) begin
         rsp <= '{rdata: (req_q.we ? '0 : ld_data), fault: 1'b0};   // stores answer zero
      end
   end

   chk_one_strobe: assert property (@(posedge clk) disable iff (!rst_n)
      !(wr_valid && rd_ready))
      else $error("read and write strobes raised together");

   chk_rsp_hold: assert property (@(posedge clk) disable iff (!rst_n)
      (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp)))
      else $error("response changed while stalled");

endmodule

// ==== logic/mem_window_regs.sv ====
// window and fault count registers
`timescale 1ns/10ps

module mem_window_regs (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic                       cfg_req,
   input  lsu_pkg::cfg_cmd_t          cfg_cmd,
   output logic                       cfg_ack,
   output logic [lsu_pkg::data_w-1:0] cfg_rdata,
   output lsu_pkg::win_t              win,
   input  logic                       fault_pulse
);
   import lsu_pkg::*;

   win_t              win_q;
   logic [data_w-1:0] faults_q;
   logic              cfg_start;
   logic              cfg_wr;

   // one access per rising phase of req
   assign cfg_start = cfg_req && !cfg_ack;
   assign cfg_wr    = cfg_start && cfg_cmd.write;
   assign win       = win_q;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         cfg_ack <= 1'b0;
      end else if (cfg_start) begin
         cfg_ack <= 1'b1;
      end else if (!cfg_req && cfg_ack) begin
         cfg_ack <= 1'b0;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         win_q.base  <= '0;
         win_q.limit <= (addr_w+1)'(mem_bytes);   // whole memory open
      end else if (cfg_wr && cfg_cmd.sel == sel_base) begin
         win_q.base <= cfg_cmd.wdata[addr_w-1:0];
      end else if (cfg_wr && cfg_cmd.sel == sel_limit) begin
         win_q.limit <= cfg_cmd.wdata[addr_w:0];
      end
   end

   // a write clears the counter whatever the data, and it sticks at all ones
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         faults_q <= '0;
      end else if (cfg_wr && cfg_cmd.sel == sel_faults) begin
         faults_q <= '0;
      end else if (fault_pulse && faults_q != '1) begin
         faults_q <= faults_q + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (cfg_start) begin
         case (cfg_cmd.sel)
            sel_base:   cfg_rdata <= data_w'(win_q.base);
            sel_limit:  cfg_rdata <= data_w'(win_q.limit);
            sel_faults: cfg_rdata <= faults_q;
            default:    cfg_rdata <= '0;
         endcase
      end
   end

   chk_ack_rise: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(cfg_ack) |-> $past(cfg_req))
      else $error("cfg_ack raised without a pending cfg_req");

endmodule

// ==== logic/mem_subsys_top.sv ====
// data memory subsystem
`timescale 1ns/10ps

module mem_subsys_top (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic                       req_valid,
   output logic                       req_ready,
   input  lsu_pkg::lsu_req_t          req,
   output logic                       rsp_valid,
   input  logic                       rsp_ready,
   output lsu_pkg::lsu_rsp_t          rsp,
   input  logic                       cfg_req,
   input  lsu_pkg::cfg_cmd_t          cfg_cmd,
   output logic                       cfg_ack,
   output logic [lsu_pkg::data_w-1:0] cfg_rdata
);
   import lsu_pkg::*;

   win_t              win;
   logic              fault_pulse;
   logic [addr_w-1:0] sram_addr;
   lsu_size_t         sram_size;
   logic [data_w-1:0] sram_wdata;
   logic [data_w-1:0] sram_rdata;
   logic              wr_valid;
   logic              wr_ready;
   logic              rd_ready;
   logic              rd_valid;

   lsu_ctrl ctrl_i (
      .clk         (clk),
      .rst_n       (rst_n),
      .req_valid   (req_valid),
      .req_ready   (req_ready),
      .req         (req),
      .rsp_valid   (rsp_valid),
      .rsp_ready   (rsp_ready),
      .rsp         (rsp),
      .win         (win),
      .fault_pulse (fault_pulse),
      .addr        (sram_addr),
      .size        (sram_size),
      .wdata       (sram_wdata),
      .wr_valid    (wr_valid),
      .rd_ready    (rd_ready),
      .wr_ready    (wr_ready),
      .rd_valid    (rd_valid),
      .rdata       (sram_rdata)
   );

   handshake_sram sram_i (
      .clk      (clk),
      .rst_n    (rst_n),
      .addr     (sram_addr),
      .size     (sram_size),
      .wdata    (sram_wdata),
      .wr_valid (wr_valid),
      .rd_ready (rd_ready),
      .wr_ready (wr_ready),
      .rd_valid (rd_valid),
      .rdata    (sram_rdata)
   );

   mem_window_regs regs_i (
      .clk         (clk),
      .rst_n       (rst_n),
      .cfg_req     (cfg_req),
      .cfg_cmd     (cfg_cmd),
      .cfg_ack     (cfg_ack),
      .cfg_rdata   (cfg_rdata),
      .win         (win),
      .fault_pulse (fault_pulse)
   );

endmodule

// ==== include/lsu_tb_model.svh ====
// data memory reference model
`ifndef LSU_TB_MODEL_SVH
`define LSU_TB_MODEL_SVH

localparam logic [31:0] lcg_seed = 32'hc9ad_e632;

logic [31:0] lcg_state = lcg_seed;
logic [7:0]  shadow_mem [0:lsu_pkg::mem_bytes-1];
logic        shadow_wr  [0:lsu_pkg::mem_bytes-1] = '{default: 1'b0};   // bytes stored so far
int unsigned model_faults = 0;

function automatic logic [31:0] lcg_next();
   lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
   return lcg_state;
endfunction

function automatic int unsigned size_bytes(lsu_pkg::lsu_size_t s);
   return (s == lsu_pkg::size_word) ? 4 : (s == lsu_pkg::size_half) ? 2 : 1;
endfunction

function automatic bit model_written(lsu_pkg::lsu_req_t r);
   bit ok;
   ok = 1'b1;
   for (int i = 0; i < size_bytes(r.size); i++)
      ok &= shadow_wr[(r.addr + i) % lsu_pkg::mem_bytes];
   return ok;
endfunction

// predicts the response and applies a legal store to the shadow memory
function automatic lsu_pkg::lsu_rsp_t model_rsp(lsu_pkg::lsu_req_t r, lsu_pkg::win_t w);
   lsu_pkg::lsu_rsp_t p;
   int unsigned       n;
   n = size_bytes(r.size);
   p = '{rdata: '0, fault: 1'b0};
   if ((r.addr % n) != 0 || r.addr < w.base || (r.addr + n) > w.limit) begin
      p.fault = 1'b1;
      model_faults++;
   end else if (r.we) begin
      for (int i = 0; i < n; i++) begin
         shadow_mem[r.addr + i] = r.wdata[8*i +: 8];
         shadow_wr[r.addr + i]  = 1'b1;
      end
   end else begin
      for (int i = 0; i < n; i++)
         p.rdata[8*i +: 8] = shadow_mem[r.addr + i];
      if (r.signed_ld && n < 4 && p.rdata[8*n-1])
         p.rdata = p.rdata | ~((32'd1 << (8*n)) - 32'd1);
   end
   return p;
endfunction

`endif

// ==== tests/tb_mem_subsys.sv ====
// data memory subsystem testbench
`timescale 1ns/10ps

module tb_mem_subsys;
   import lsu_pkg::*;
   `include "lsu_tb_model.svh"

   localparam int timeout_cycles = 40;

   logic              clk;
   logic              rst_n;
   logic              req_valid;
   logic              req_ready;
   lsu_req_t          req;
   logic              rsp_valid;
   logic              rsp_ready;
   lsu_rsp_t          rsp;
   logic              cfg_req;
   cfg_cmd_t          cfg_cmd;
   logic              cfg_ack;
   logic [data_w-1:0] cfg_rdata;
   win_t              win_model;   // window as last programmed through cfg

   mem_subsys_top dut_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .req_valid (req_valid),
      .req_ready (req_ready),
      .req       (req),
      .rsp_valid (rsp_valid),
      .rsp_ready (rsp_ready),
      .rsp       (rsp),
      .cfg_req   (cfg_req),
      .cfg_cmd   (cfg_cmd),
      .cfg_ack   (cfg_ack),
      .cfg_rdata (cfg_rdata)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   task automatic abort_run();
      $display("Result: FAILED");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
      assert (got === exp) else begin
         $display("[FAIL] time %0t: %s was %h, expected %h", $time, name, got, exp);
         abort_run();
      end
   endtask

   task automatic tick_or_timeout(inout int n, input string what);
      n++;
      if (n > timeout_cycles) begin
         $display("timed out waiting for %s", what);
         abort_run();
      end else begin
         @(negedge clk);
      end
   endtask

   // the low LCG bits have a short period so only the upper ones are used
   function automatic int unsigned rand_below(int unsigned m);
      return (lcg_next() >> 8) % m;
   endfunction

   function automatic lsu_req_t make_req(lsu_size_t s, int unsigned a, bit we, bit sgn);
      lsu_req_t r;
      r.addr      = a[addr_w-1:0];
      r.size      = s;
      r.we        = we;
      r.signed_ld = sgn;
      r.wdata     = lcg_next();
      return r;
   endfunction

   task automatic send_req(input lsu_req_t r);
      int n;
      n = 0;
      @(posedge clk);
      req       <= r;
      req_valid <= 1'b1;
      @(negedge clk);
      while (!req_ready) tick_or_timeout(n, "req_ready");
      @(posedge clk);   // transfer edge
      req_valid <= 1'b0;
   endtask

   task automatic recv_rsp(input int stall, output lsu_rsp_t got);
      lsu_rsp_t held;
      int       n;
      n = 0;
      @(negedge clk);
      while (!rsp_valid) tick_or_timeout(n, "rsp_valid");
      held = rsp;
      for (int i = 0; i < stall; i++) begin
         @(negedge clk);
         check_val("rsp_valid", rsp_valid, 1'b1);
         check_val("rsp.rdata", rsp.rdata, held.rdata);
         check_val("rsp.fault", rsp.fault, held.fault);
         check_val("req_ready", req_ready, 1'b0);   // nothing accepted while stalled
      end
      @(posedge clk);
      rsp_ready <= 1'b1;
      @(posedge clk);
      rsp_ready <= 1'b0;
      got = held;
   endtask

   task automatic run_access(input lsu_req_t r, input int stall);
      lsu_rsp_t exp;
      lsu_rsp_t got;
      exp = model_rsp(r, win_model);
      send_req(r);
      recv_rsp(stall, got);
      check_val("rsp.fault", got.fault, exp.fault);
      check_val("rsp.rdata", got.rdata, exp.rdata);
   endtask

   // accesses in the first 64 bytes of the window so loads find written data
   task automatic random_inside(input int count, input int max_stall);
      lsu_req_t    r;
      lsu_size_t   s;
      int unsigned n;
      for (int i = 0; i < count; i++) begin
         s = lsu_size_t'(rand_below(3) + 1);
         n = size_bytes(s);
         r = make_req(s, win_model.base + rand_below(64 / n) * n, rand_below(2), rand_below(2));
         if (!r.we && !model_written(r))
            r.we = 1'b1;
         run_access(r, (max_stall > 0) ? rand_below(max_stall + 1) : 0);
      end
   endtask

   task automatic cfg_access(input bit wr, input cfg_sel_t sel, input logic [31:0] wdata,
                             output logic [31:0] rdata);
      int n;
      n = 0;
      @(posedge clk);
      cfg_cmd <= '{write: wr, sel: sel, wdata: wdata};
      cfg_req <= 1'b1;
      @(negedge clk);
      while (!cfg_ack) tick_or_timeout(n, "cfg_ack to rise");
      rdata = cfg_rdata;
      @(posedge clk);
      cfg_req <= 1'b0;
      n = 0;
      @(negedge clk);
      while (cfg_ack) tick_or_timeout(n, "cfg_ack to fall");
   endtask

   initial begin
      logic [31:0] rd;
      int unsigned a;
      rst_n     = 1'b0;
      req_valid = 1'b0;
      req       = '0;
      rsp_ready = 1'b0;
      cfg_req   = 1'b0;
      cfg_cmd   = '0;
      win_model = '{base: '0, limit: (addr_w+1)'(mem_bytes)};
      repeat (4) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
      check_val("rsp_valid", rsp_valid, 1'b0);
      check_val("cfg_ack", cfg_ack, 1'b0);
      cfg_access(1'b0, sel_base, 32'h0, rd);
      check_val("window base", rd, 32'h0);
      cfg_access(1'b0, sel_limit, 32'h0, rd);
      check_val("window limit", rd, mem_bytes);
      cfg_access(1'b0, sel_faults, 32'h0, rd);
      check_val("fault count", rd, 32'h0);

      random_inside(150, 0);

      for (int i = 0; i < 8; i++) begin
         a = rand_below(16) * 4;
         run_access(make_req(size_word, a, 1'b1, 1'b0), 0);
         run_access(make_req(size_word, a + 1 + rand_below(3), 1'b1, 1'b0), 0);
         run_access(make_req(size_half, a + 1, 1'b1, 1'b0), 0);
         run_access(make_req(size_half, a + 3, 1'b0, 1'b1), 0);
         run_access(make_req(size_word, a, 1'b0, 1'b0), 0);   // memory left unchanged
      end

      cfg_access(1'b1, sel_base, 32'h100, rd);
      win_model.base = 12'h100;
      cfg_access(1'b1, sel_limit, 32'h200, rd);
      win_model.limit = 13'h200;
      cfg_access(1'b0, sel_base, 32'h0, rd);
      check_val("window base", rd, 32'h100);
      cfg_access(1'b0, sel_limit, 32'h0, rd);
      check_val("window limit", rd, 32'h200);
      random_inside(60, 0);
      run_access(make_req(size_word, 32'h1fc, 1'b1, 1'b0), 0);
      run_access(make_req(size_byte, 32'h200, 1'b1, 1'b0), 0);
      run_access(make_req(size_word, 32'h0fc, 1'b0, 1'b0), 0);
      for (int i = 0; i < 16; i++) begin
         a = rand_below(2) ? rand_below(64) * 4 : 32'h200 + rand_below(64) * 4;
         run_access(make_req(size_word, a, rand_below(2), 1'b0), 0);
      end

      cfg_access(1'b0, sel_faults, 32'h0, rd);
      check_val("fault count", rd, model_faults);
      cfg_access(1'b1, sel_faults, 32'hffff_ffff, rd);
      model_faults = 0;
      cfg_access(1'b0, sel_faults, 32'h0, rd);
      check_val("fault count", rd, 32'h0);

      random_inside(60, 6);   // responses held back for random stretches

      $display("Result: PASSED");
      $finish;
   end

endmodule

// ==== project.f ====
+incdir+include
logic/lsu_pkg.sv
logic/handshake_sram.sv
logic/lsu_ctrl.sv
logic/mem_window_regs.sv
logic/mem_subsys_top.sv
tests/tb_mem_subsys.sv
